// File: design/hba_bridge_defines.svh
// Widths are fixed by the HBA bus definition; UART_CLKS_PER_BIT is a simulation value
`ifndef HBA_BRIDGE_DEFINES_SVH
`define HBA_BRIDGE_DEFINES_SVH

// HBA bus widths
`define HBA_DBUS_WIDTH 8          // Data bus
`define HBA_PERIPH_ADDR_WIDTH 4   // Peripheral number, upper address bits
`define HBA_REG_ADDR_WIDTH 8      // Register address, lower address bits
`define HBA_ADDR_WIDTH (`HBA_PERIPH_ADDR_WIDTH + `HBA_REG_ADDR_WIDTH)

// Serial bit time in hba_clk cycles
// Short value keeps simulation fast
// On hardware use 521 for a 60 MHz clock at 115200 baud
`define UART_CLKS_PER_BIT 8

// Reply character after the last bus write
`define BRIDGE_ACK_CHAR 8'hAC

`endif

// File: design/hba_bridge_pkg.sv
// Types only; widths come from hba_bridge_defines.svh, enum literals carry a unit prefix
`include "hba_bridge_defines.svh"

package hba_bridge_pkg;

    // Plain vectors with a meaning
    typedef logic [`HBA_DBUS_WIDTH-1:0]        hba_data_t;
    typedef logic [`HBA_ADDR_WIDTH-1:0]        hba_addr_t;
    typedef logic [`HBA_PERIPH_ADDR_WIDTH-1:0] periph_addr_t;
    typedef logic [`HBA_REG_ADDR_WIDTH-1:0]    reg_addr_t;
    typedef logic [7:0]                        serial_byte_t;
    typedef logic [3:0]                        xfer_count_t;   // Up to 8 transfers left

    // Command byte as sent by the host, bit 7 first
    typedef struct packed {
        logic         rnw;               // 1 = read, 0 = write
        logic [2:0]   count_minus_one;   // Transfers minus one
        periph_addr_t periph;            // Target peripheral
    } cmd_fields_t;

    // One bus transfer, held stable until done
    typedef struct packed {
        logic      rnw;
        hba_addr_t addr;    // {periph, reg}
        hba_data_t wdata;   // Ignored on reads
    } hba_req_t;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

    typedef enum logic [1:0] {M_IDLE, M_REQUEST, M_XFER} master_state_t;

    typedef enum logic [3:0] {
        ST_CMD, ST_REG_ADDR, ST_ECHO_CMD, ST_ECHO_REG, ST_SETUP,
        ST_GET_DATA, ST_BUS_WAIT, ST_SEND_DATA, ST_ACK, ST_DONE
    } engine_state_t;

endpackage

// File: design/uart_rx.sv
// 8N1 only, fixed bit time; no read strobe, so rx_byte is only valid with the rx_valid pulse
`include "hba_bridge_defines.svh"

module uart_rx
    import hba_bridge_pkg::*;
(
    input  logic         hba_clk,
    input  logic         hba_reset,
    input  logic         rxd,
    output serial_byte_t rx_byte,
    output logic         rx_valid
);
    localparam int unsigned BIT_LAST  = `UART_CLKS_PER_BIT - 1;
    localparam int unsigned HALF_LAST = BIT_LAST / 2;

    rx_state_t    state;
    logic         rxd_meta;     // First sync stage
    logic         rxd_sync;     // Safe to use
    logic [15:0]  clk_cnt;      // Cycles inside current bit
    logic [2:0]   bit_idx;
    logic         bit_tick;     // Middle of a data or stop bit
    serial_byte_t shift_q;

    assign bit_tick = (clk_cnt == 16'(BIT_LAST));

    // Line idles high, so sync flops reset high
    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;   // Single cycle pulse
            clk_cnt  <= clk_cnt + 16'd1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rxd_sync) state <= RX_START;   // Falling edge
                end
                RX_START: begin
                    // Recheck at half a bit, glitches go back to idle
                    if (clk_cnt == 16'(HALF_LAST)) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_tick) begin
                        rx_valid <= rxd_sync;   // Framing error drops the byte
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Data path, LSB arrives first
    always_ff @(posedge hba_clk) begin
        if (state == RX_DATA && bit_tick) shift_q <= {rxd_sync, shift_q[7:1]};
        if (state == RX_STOP && bit_tick) rx_byte <= shift_q;
    end

endmodule

// File: design/uart_tx.sv
// 8N1 only, fixed bit time; tx_start is ignored while tx_busy is high
`include "hba_bridge_defines.svh"

module uart_tx
    import hba_bridge_pkg::*;
(
    input  logic         hba_clk,
    input  logic         hba_reset,
    input  serial_byte_t tx_byte,
    input  logic         tx_start,
    output logic         txd,
    output logic         tx_busy
);
    localparam int unsigned BIT_LAST = `UART_CLKS_PER_BIT - 1;

    tx_state_t    state;
    logic [15:0]  clk_cnt;
    logic [2:0]   bit_idx;
    logic         bit_end;     // Last cycle of the current bit
    serial_byte_t shift_q;     // Remaining data bits

    assign bit_end = (clk_cnt == 16'(BIT_LAST));

    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;   // Idle mark
            tx_busy <= 1'b0;
        end else begin
            clk_cnt <= bit_end ? 16'd0 : clk_cnt + 16'd1;
            case (state)
                TX_IDLE: begin
                    clk_cnt <= '0;
                    if (tx_start) begin
                        txd     <= 1'b0;   // Start bit
                        tx_busy <= 1'b1;
                        state   <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        txd     <= shift_q[0];
                        bit_idx <= '0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            txd   <= 1'b1;   // Stop bit
                            state <= TX_STOP;
                        end else begin
                            txd <= shift_q[0];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        tx_busy <= 1'b0;   // Full 10 bit times spent
                        state   <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Byte captured on start, shifted out LSB first
    always_ff @(posedge hba_clk) begin
        if (state == TX_IDLE && tx_start) begin
            shift_q <= tx_byte;
        end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

// File: design/hba_master.sv
// One transfer per bus_start; bus_req must stay stable until bus_done, outputs zero when idle
`include "hba_bridge_defines.svh"

module hba_master
    import hba_bridge_pkg::*;
(
    input  logic      hba_clk,
    input  logic      hba_reset,
    // Sequencer side
    input  hba_req_t  bus_req,
    input  logic      bus_start,
    output hba_data_t bus_rdata,
    output logic      bus_done,
    // HBA master port
    input  logic      hba_mgrant,
    input  logic      hba_xferack,
    input  hba_data_t hba_dbus,
    output logic      hba_mrequest,
    output hba_addr_t hba_abus_master,
    output logic      hba_rnw_master,
    output logic      hba_select_master,
    output hba_data_t hba_dbus_master
);
    master_state_t state;

    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            state             <= M_IDLE;
            bus_done          <= 1'b0;
            hba_mrequest      <= 1'b0;
            hba_abus_master   <= '0;
            hba_rnw_master    <= 1'b0;
            hba_select_master <= 1'b0;
            hba_dbus_master   <= '0;
        end else begin
            bus_done <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (bus_start) begin
                        hba_mrequest <= 1'b1;   // Ask arbiter
                        state        <= M_REQUEST;
                    end
                end
                M_REQUEST: begin
                    if (hba_mgrant) begin
                        hba_select_master <= 1'b1;
                        hba_abus_master   <= bus_req.addr;
                        hba_rnw_master    <= bus_req.rnw;
                        // Write data only on writes
                        hba_dbus_master   <= bus_req.rnw ? '0 : bus_req.wdata;
                        state             <= M_XFER;
                    end
                end
                M_XFER: begin
                    if (hba_xferack) begin   // Slave finished
                        hba_select_master <= 1'b0;
                        hba_mrequest      <= 1'b0;
                        hba_abus_master   <= '0;
                        hba_rnw_master    <= 1'b0;
                        hba_dbus_master   <= '0;
                        bus_done          <= 1'b1;
                        state             <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // Read data captured along with the ack
    always_ff @(posedge hba_clk) begin
        if (state == M_XFER && hba_xferack) bus_rdata <= hba_dbus;
    end

endmodule

// File: design/serial_cmd_engine.sv
// Host must not send a new command until the reply ends; unexpected serial bytes are dropped
`include "hba_bridge_defines.svh"

module serial_cmd_engine
    import hba_bridge_pkg::*;
(
    input  logic         hba_clk,
    input  logic         hba_reset,
    // Receiver
    input  serial_byte_t rx_byte,
    input  logic         rx_valid,
    // Transmitter
    output serial_byte_t tx_byte,
    output logic         tx_start,
    input  logic         tx_busy,
    // Bus master
    output hba_req_t     bus_req,
    output logic         bus_start,
    input  hba_data_t    bus_rdata,
    input  logic         bus_done
);
    engine_state_t state;
    cmd_fields_t   cmd_q;        // Command byte as received
    reg_addr_t     reg_addr_q;   // Auto-incremented register address
    xfer_count_t   count_q;      // Transfers still to do
    hba_data_t     rdata_q;      // Read byte waiting for the transmitter
    logic          send_state;   // State that owns a reply byte

    // Reply byte per state
    always_comb begin
        case (state)
            ST_ECHO_CMD:  tx_byte = serial_byte_t'(cmd_q);
            ST_ECHO_REG:  tx_byte = reg_addr_q;   // Not yet incremented here
            ST_SEND_DATA: tx_byte = rdata_q;
            default:      tx_byte = `BRIDGE_ACK_CHAR;
        endcase
    end

    assign send_state = (state == ST_ECHO_CMD) || (state == ST_ECHO_REG) ||
                        (state == ST_SEND_DATA) || (state == ST_ACK);
    // Start combinational so the busy level is up before the next send
    assign tx_start   = send_state && !tx_busy;

    always_ff @(posedge hba_clk) begin
        if (hba_reset) begin
            state     <= ST_CMD;
            count_q   <= '0;
            bus_start <= 1'b0;
        end else begin
            bus_start <= 1'b0;   // Pulse
            case (state)
                ST_CMD: begin
                    if (rx_valid) state <= ST_REG_ADDR;
                end
                ST_REG_ADDR: begin
                    if (rx_valid) begin
                        count_q <= xfer_count_t'(cmd_q.count_minus_one) + 4'd1;
                        state   <= cmd_q.rnw ? ST_ECHO_CMD : ST_SETUP;
                    end
                end
                ST_ECHO_CMD: if (!tx_busy) state <= ST_ECHO_REG;
                ST_ECHO_REG: if (!tx_busy) state <= ST_SETUP;
                ST_SETUP: begin
                    if (count_q == '0) begin
                        state <= cmd_q.rnw ? ST_DONE : ST_ACK;   // Reads end on last byte
                    end else begin
                        count_q <= count_q - 4'd1;
                        if (cmd_q.rnw) begin
                            bus_start <= 1'b1;   // Read needs nothing from the host
                            state     <= ST_BUS_WAIT;
                        end else begin
                            state <= ST_GET_DATA;
                        end
                    end
                end
                ST_GET_DATA: begin
                    if (rx_valid) begin
                        bus_start <= 1'b1;
                        state     <= ST_BUS_WAIT;
                    end
                end
                ST_BUS_WAIT: begin
                    if (bus_done) state <= cmd_q.rnw ? ST_SEND_DATA : ST_SETUP;
                end
                ST_SEND_DATA: if (!tx_busy) state <= ST_SETUP;
                ST_ACK:       if (!tx_busy) state <= ST_DONE;
                ST_DONE:      if (!tx_busy) state <= ST_CMD;   // Let last byte drain
                default:      state <= ST_CMD;
            endcase
        end
    end

    // Payload registers, qualified by state
    always_ff @(posedge hba_clk) begin
        if (state == ST_CMD && rx_valid) cmd_q <= cmd_fields_t'(rx_byte);
        if (state == ST_REG_ADDR && rx_valid) reg_addr_q <= rx_byte;
        if (state == ST_SETUP && count_q != '0) begin
            bus_req.rnw   <= cmd_q.rnw;
            bus_req.addr  <= {cmd_q.periph, reg_addr_q};   // Peripheral on top
            bus_req.wdata <= '0;
            reg_addr_q    <= reg_addr_q + 8'd1;            // Wraps inside peripheral
        end
        if (state == ST_GET_DATA && rx_valid) bus_req.wdata <= rx_byte;
        if (state == ST_BUS_WAIT && bus_done) rdata_q <= bus_rdata;
    end

endmodule

// File: design/serial_hba_bridge.sv
// Fixed baud from UART_CLKS_PER_BIT; HBA master port only, no slave registers or interrupts
module serial_hba_bridge
    import hba_bridge_pkg::*;
(
    input  logic      hba_clk,
    input  logic      hba_reset,
    // Serial link
    input  logic      io_rxd,
    output logic      io_txd,
    // HBA master port
    input  logic      hba_mgrant,
    input  logic      hba_xferack,
    input  hba_data_t hba_dbus,
    output logic      hba_mrequest,
    output hba_addr_t hba_abus_master,
    output logic      hba_rnw_master,
    output logic      hba_select_master,
    output hba_data_t hba_dbus_master
);
    serial_byte_t rx_byte;    // Valid with rx_valid only
    logic         rx_valid;
    serial_byte_t tx_byte;
    logic         tx_start;
    logic         tx_busy;
    hba_req_t     bus_req;
    logic         bus_start;
    hba_data_t    bus_rdata;
    logic         bus_done;

    uart_rx u_uart_rx (
        .hba_clk   (hba_clk),
        .hba_reset (hba_reset),
        .rxd       (io_rxd),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid)
    );

    uart_tx u_uart_tx (
        .hba_clk   (hba_clk),
        .hba_reset (hba_reset),
        .tx_byte   (tx_byte),
        .tx_start  (tx_start),
        .txd       (io_txd),
        .tx_busy   (tx_busy)
    );

    serial_cmd_engine u_engine (
        .hba_clk   (hba_clk),
        .hba_reset (hba_reset),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .tx_byte   (tx_byte),
        .tx_start  (tx_start),
        .tx_busy   (tx_busy),
        .bus_req   (bus_req),
        .bus_start (bus_start),
        .bus_rdata (bus_rdata),
        .bus_done  (bus_done)
    );

    hba_master u_master (
        .hba_clk           (hba_clk),
        .hba_reset         (hba_reset),
        .bus_req           (bus_req),
        .bus_start         (bus_start),
        .bus_rdata         (bus_rdata),
        .bus_done          (bus_done),
        .hba_mgrant        (hba_mgrant),
        .hba_xferack       (hba_xferack),
        .hba_dbus          (hba_dbus),
        .hba_mrequest      (hba_mrequest),
        .hba_abus_master   (hba_abus_master),
        .hba_rnw_master    (hba_rnw_master),
        .hba_select_master (hba_select_master),
        .hba_dbus_master   (hba_dbus_master)
    );

endmodule

// File: test/tb_clock_gen.sv
// Clock period is 20 time units; reset stays high through the first 3 rising edges
module tb_clock_gen (
    output logic hba_clk,
    output logic hba_reset
);
    initial begin
        hba_clk = 1'b0;
        forever #10 hba_clk = ~hba_clk;   // Period 20
    end

    initial begin
        hba_reset = 1'b1;
        repeat (3) @(posedge hba_clk);
        #1 hba_reset = 1'b0;   // Released just after the edge like other inputs
    end

endmodule

// File: test/tb_serial_hba_bridge.sv
// Run from the project root; reads test/bridge_stimulus.txt, slave memory preset mixes all 12 bits
`include "hba_bridge_defines.svh"

module tb_serial_hba_bridge
    import hba_bridge_pkg::*;
();
    localparam int BIT_CYC  = `UART_CLKS_PER_BIT;
    localparam int BYTE_CYC = 10 * BIT_CYC;   // Start, 8 data, stop

    logic      hba_clk;
    logic      hba_reset;
    logic      io_rxd;
    logic      io_txd;
    logic      hba_mgrant;
    logic      hba_xferack;
    hba_data_t hba_dbus;
    logic      hba_mrequest;
    hba_addr_t hba_abus_master;
    logic      hba_rnw_master;
    logic      hba_select_master;
    hba_data_t hba_dbus_master;

    // Stimulus table, byte lists flattened across tests
    string        test_name [$];
    int           send_len [$];
    int           reply_len [$];
    serial_byte_t send_bytes [$];
    serial_byte_t reply_bytes [$];

    serial_byte_t rx_seen [$];       // Filled by the serial monitor
    hba_addr_t    wr_addr_log [$];   // Writes seen by the slave model
    hba_data_t    wr_data_log [$];
    hba_data_t    mem [0:4095];
    int           error_count = 0;
    longint       watchdog_limit = 0;

    tb_clock_gen u_clk_gen (
        .hba_clk   (hba_clk),
        .hba_reset (hba_reset)
    );

    serial_hba_bridge u_dut (
        .hba_clk           (hba_clk),
        .hba_reset         (hba_reset),
        .io_rxd            (io_rxd),
        .io_txd            (io_txd),
        .hba_mgrant        (hba_mgrant),
        .hba_xferack       (hba_xferack),
        .hba_dbus          (hba_dbus),
        .hba_mrequest      (hba_mrequest),
        .hba_abus_master   (hba_abus_master),
        .hba_rnw_master    (hba_rnw_master),
        .hba_select_master (hba_select_master),
        .hba_dbus_master   (hba_dbus_master)
    );

    task automatic next_cycle();
        @(posedge hba_clk);
        #1;   // Past the DUT flop updates
    endtask

    task automatic load_stimulus();
        int    fd;
        int    n;
        int    b;
        int    code;
        string name;
        string rest;
        fd = $fopen("test/bridge_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/bridge_stimulus.txt");
            error_count++;
            return;
        end
        while ($fscanf(fd, "%s", name) == 1) begin
            if (name.getc(0) == "#") begin
                code = $fgets(rest, fd);   // Rest of a comment line
                continue;
            end
            test_name.push_back(name);
            code = $fscanf(fd, "%h", n);
            send_len.push_back(n);
            repeat (n) begin
                code = $fscanf(fd, "%h", b);
                send_bytes.push_back(serial_byte_t'(b));
            end
            code = $fscanf(fd, "%h", n);
            reply_len.push_back(n);
            repeat (n) begin
                code = $fscanf(fd, "%h", b);
                reply_bytes.push_back(serial_byte_t'(b));
            end
        end
        $fclose(fd);
        if (test_name.size() == 0) begin
            $display("The stimulus file holds no tests");
            error_count++;
        end
    endtask

    // Caller stands just after an edge; each bit lasts BIT_CYC cycles
    task automatic drive_bit(input logic value);
        io_rxd = value;
        repeat (BIT_CYC) next_cycle();
    endtask

    task automatic send_serial_byte(input serial_byte_t value);
        drive_bit(1'b0);   // Start bit
        for (int i = 0; i < 8; i++) begin
            drive_bit(value[i]);   // LSB first
        end
        drive_bit(1'b1);   // Stop bit
    endtask

    task automatic check_serial_byte(input serial_byte_t got, input serial_byte_t expected,
                                     input string what);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s got %02h, expected %02h", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic check_bus_write(input hba_addr_t got_addr, input hba_data_t got_data,
                                   input hba_addr_t exp_addr, input hba_data_t exp_data,
                                   input string what);
        if (got_addr !== exp_addr || got_data !== exp_data) begin
            $display("MISMATCH at %0t: %s wrote %03h=%02h, expected %03h=%02h",
                     $time, what, got_addr, got_data, exp_addr, exp_data);
            error_count++;
        end
    endtask

    // Expected writes follow from the command byte, the address byte and the data bytes
    task automatic check_write_log(input string name, input int s_off);
        cmd_fields_t cmd;
        reg_addr_t   first_reg;
        int          count;
        cmd       = cmd_fields_t'(send_bytes[s_off]);
        first_reg = send_bytes[s_off + 1];
        count     = cmd.rnw ? 0 : int'(cmd.count_minus_one) + 1;   // Reads write nothing
        if (wr_addr_log.size() != count) begin
            $display("%s: slave saw %0d bus writes where %0d were due",
                     name, wr_addr_log.size(), count);
            error_count++;
        end else begin
            for (int i = 0; i < count; i++) begin
                check_bus_write(wr_addr_log[i], wr_data_log[i],
                                {cmd.periph, reg_addr_t'(int'(first_reg) + i)},   // Wraps in 8 bits
                                send_bytes[s_off + 2 + i], $sformatf("%s write %0d", name, i));
            end
        end
    endtask

    task automatic run_one_test(input int t, input int s_off, input int r_off, output bit ok);
        int errs_before;
        int cyc;
        int limit;
        errs_before = error_count;
        rx_seen.delete();
        wr_addr_log.delete();
        wr_data_log.delete();
        for (int i = 0; i < send_len[t]; i++) begin
            send_serial_byte(send_bytes[s_off + i]);
        end
        limit = (send_len[t] + reply_len[t] + 4) * BYTE_CYC * 2;
        cyc   = 0;
        while (rx_seen.size() < reply_len[t] && cyc < limit) begin   // Reply may be under way
            next_cycle();
            cyc++;
        end
        repeat (2 * BYTE_CYC) next_cycle();   // Room for a stray extra byte
        if (rx_seen.size() != reply_len[t]) begin
            $display("%s: expected %0d reply bytes but received %0d",
                     test_name[t], reply_len[t], rx_seen.size());
            error_count++;
        end
        for (int i = 0; i < reply_len[t] && i < rx_seen.size(); i++) begin
            check_serial_byte(rx_seen[i], reply_bytes[r_off + i],
                              $sformatf("%s reply byte %0d", test_name[t], i));
        end
        check_write_log(test_name[t], s_off);
        ok = (error_count == errs_before);
    endtask

    // Samples io_txd in the middle of every bit
    initial begin : serial_monitor
        serial_byte_t value;
        @(negedge hba_reset);
        forever begin
            @(negedge io_txd);
            repeat (BIT_CYC / 2) next_cycle();   // Middle of start bit
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CYC) next_cycle();
                value[i] = io_txd;
            end
            repeat (BIT_CYC) next_cycle();
            if (io_txd !== 1'b1) begin
                $display("Reply byte ending at %0t has no stop bit", $time);
                error_count++;
            end else begin
                rx_seen.push_back(value);
            end
        end
    end

    // HBA slave with arbiter, random grant and ack delays
    initial begin : bus_slave
        int        delay;
        hba_addr_t addr;
        void'($urandom(32'hb982_f16d));   // Only process drawing random numbers
        hba_mgrant  = 1'b0;
        hba_xferack = 1'b0;
        hba_dbus    = '0;
        for (int i = 0; i < 4096; i++) begin
            addr   = hba_addr_t'(i);
            mem[i] = addr[7:0] ^ 8'h5A ^ {addr[11:8], 4'h0};
        end
        forever begin
            next_cycle();
            if (hba_mrequest === 1'b1) begin
                delay = int'($urandom_range(5, 0));
                repeat (delay) next_cycle();
                hba_mgrant = 1'b1;
                while (hba_select_master !== 1'b1) next_cycle();
                delay = int'($urandom_range(4, 1));
                repeat (delay - 1) next_cycle();   // Master sees ack one edge later
                addr = hba_abus_master;
                if (hba_rnw_master === 1'b1) begin
                    hba_dbus = mem[addr];
                end else begin
                    mem[addr] = hba_dbus_master;
                    wr_addr_log.push_back(addr);
                    wr_data_log.push_back(hba_dbus_master);
                end
                hba_xferack = 1'b1;
                next_cycle();
                hba_xferack = 1'b0;
                hba_mgrant  = 1'b0;
                hba_dbus    = '0;
            end
        end
    end

    initial begin : watchdog
        wait (watchdog_limit != 0);
        #(watchdog_limit);
        $display("Watchdog expired before all tests finished");
        $display("test failed");
        $finish;
    end

    initial begin : main_sequence
        int s_off;
        int r_off;
        int passed;
        int failed;
        bit ok;
        s_off  = 0;
        r_off  = 0;
        passed = 0;
        failed = 0;
        io_rxd = 1'b1;   // Line idle
        load_stimulus();
        watchdog_limit = longint'(test_name.size() > 0 ? test_name.size() : 1) * 24 *
                         BYTE_CYC * 20 * 2;
        @(negedge hba_reset);
        next_cycle();
        if (io_txd !== 1'b1 || hba_mrequest !== 1'b0 || hba_select_master !== 1'b0 ||
            hba_rnw_master !== 1'b0 || hba_abus_master !== '0 || hba_dbus_master !== '0) begin
            $display("MISMATCH at %0t: DUT outputs are not idle after reset", $time);
            error_count++;
        end
        for (int t = 0; t < test_name.size(); t++) begin
            run_one_test(t, s_off, r_off, ok);
            $display("%s: %s", test_name[t], ok ? "ok" : "FAILED");
            if (ok) begin
                passed++;
            end else begin
                failed++;
            end
            s_off += send_len[t];
            r_off += reply_len[t];
        end
        $display("%0d tests run, %0d ok, %0d failed, %0d errors",
                 test_name.size(), passed, failed, error_count);
        if (error_count == 0 && failed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: test/bridge_stimulus.txt
# name  send_count send_bytes...  reply_count reply_bytes...  (counts and bytes in hex)
# Slave memory preset per address: addr[7:0] ^ 5A ^ {addr[11:8], 0}
rd_single      2 83 10              3 83 10 7A
rd_burst_wrap  2 F5 FC              A F5 FC F6 F7 F4 F5 0A 0B 08 09
wr_single      3 06 00 3C           1 AC
rd_after_wr    2 86 00              3 86 00 3C
wr_burst       6 32 40 11 22 33 44  1 AC
rd_burst_back  2 B2 40              6 B2 40 11 22 33 44
rd_periph0     2 80 7F              3 80 7F 25
rd_periph15    2 9F FF              4 9F FF 55 AA
rd_periph15_b  2 8F 33              3 8F 33 99

// File: compile.f
+incdir+design
design/hba_bridge_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/hba_master.sv
design/serial_cmd_engine.sv
design/serial_hba_bridge.sv
test/tb_clock_gen.sv
test/tb_serial_hba_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the bridge testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f compile.f --top-module tb_serial_hba_bridge
./obj_dir/Vtb_serial_hba_bridge > sim.log 2>&1
cat sim.log
if grep -q "test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
echo "Simulation finished, see sim.log"
